// ==== include/glue_params.svh ====
// ----------------------------------------
// glue register map, reset defaults
// and counter sizes
// ----------------------------------------

`ifndef GLUE_PARAMS_SVH
`define GLUE_PARAMS_SVH

// host register addresses
`define GLUE_ADDR_MEM         4'h0
`define GLUE_ADDR_CPU         4'h1
`define GLUE_ADDR_CHIPSET     4'h2
`define GLUE_ADDR_CTRL        4'h3

// ----------------------------------------
// control register bits
// ----------------------------------------
`define GLUE_CTRL_USRRST_BIT  0    // self clearing
`define GLUE_CTRL_CPURST_BIT  1
`define GLUE_CTRL_CPUHLT_BIT  2

// frame starts seen before sys reset drops
`define GLUE_RESET_FRAMES     4

// power led pwm counter
`define GLUE_LED_CNT_W        4

// config after power-on reset
`define GLUE_MEM_DEFAULT      6'h01  // 1 MB chip
`define GLUE_CHIPSET_DEFAULT  5'h00  // pal, ocs

`endif

// ==== logic/glue_pkg.sv ====
// ----------------------------------------
// shared types of the system glue
// register bus vectors, config vectors,
// interrupt level and reset FSM states
// ----------------------------------------

package glue_pkg;

	// ----------------------------------------
	// host register bus
	// ----------------------------------------
	typedef logic [3:0]  reg_addr_t;   // register select
	typedef logic [15:0] reg_data_t;   // read and write data

	// ----------------------------------------
	// configuration vectors
	// ----------------------------------------

	// [1:0] chip ram size, 3 is 2 MB
	typedef logic [5:0] mem_cfg_t;

	// [2] fast chip, [3] fast kick
	typedef logic [3:0] cpu_cfg_t;

	// [1] ntsc
	typedef logic [4:0] chipset_cfg_t;

	// ----------------------------------------
	// interrupts
	// ----------------------------------------
	typedef logic [2:0] ipl_t;         // m68k ipl, active low
	typedef logic [5:0] irq_vec_t;     // bit n is level n+1

	// reset sequencer states
	typedef enum logic [1:0] {
		RST_HOLD,                       // source active
		RST_COUNT,                      // waiting for frame starts
		RST_RUN                         // system released
	} rst_state_t;

endpackage

// ==== logic/sys_config_regs.sv ====
// ----------------------------------------
// host configuration registers
// readback port, user reset pulse
// and the pal/ntsc latch
// ----------------------------------------
`timescale 1ns/1ps
`include "glue_params.svh"

module sys_config_regs (
	input  logic                   clk,
	input  logic                   reset,         // power-on only
	input  glue_pkg::reg_addr_t    host_addr_i,
	input  glue_pkg::reg_data_t    host_wdata_i,
	input  logic                   host_we_i,
	input  logic                   host_re_i,
	output glue_pkg::reg_data_t    host_rdata_o,
	input  logic                   sys_reset_i,   // from reset sequencer
	output glue_pkg::mem_cfg_t     mem_cfg_o,
	output glue_pkg::cpu_cfg_t     cpu_cfg_o,
	output logic                   ntsc_o,
	output logic                   usr_reset_o,   // one cycle pulse
	output logic                   cpu_rst_o,
	output logic                   cpu_halt_o
);

	localparam int NTSC_BIT = 1;   // in chipset reg

	glue_pkg::mem_cfg_t     mem_cfg_q;
	glue_pkg::cpu_cfg_t     cpu_cfg_q;
	glue_pkg::chipset_cfg_t chipset_cfg_q;
	glue_pkg::reg_data_t    rd_mux;
	glue_pkg::reg_data_t    rdata_q;
	logic                   cpu_rst_q;
	logic                   cpu_halt_q;
	logic                   usr_reset_q;
	logic                   ntsc_q;
	logic                   wr_ctrl;

	assign wr_ctrl = host_we_i && (host_addr_i == `GLUE_ADDR_CTRL);

	// ----------------------------------------
	// register writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_cfg_q     <= `GLUE_MEM_DEFAULT;
			cpu_cfg_q     <= '0;
			chipset_cfg_q <= `GLUE_CHIPSET_DEFAULT;
			cpu_rst_q     <= 1'b0;
			cpu_halt_q    <= 1'b0;
			usr_reset_q   <= 1'b0;
		end else begin
			usr_reset_q <= wr_ctrl & host_wdata_i[`GLUE_CTRL_USRRST_BIT];   // never held
			if (host_we_i) begin
				case (host_addr_i)
					`GLUE_ADDR_MEM:     mem_cfg_q <= host_wdata_i[$bits(mem_cfg_q)-1:0];
					`GLUE_ADDR_CPU:     cpu_cfg_q <= host_wdata_i[$bits(cpu_cfg_q)-1:0];
					`GLUE_ADDR_CHIPSET: chipset_cfg_q <= host_wdata_i[$bits(chipset_cfg_q)-1:0];
					`GLUE_ADDR_CTRL: begin
						cpu_rst_q  <= host_wdata_i[`GLUE_CTRL_CPURST_BIT];   // level
						cpu_halt_q <= host_wdata_i[`GLUE_CTRL_CPUHLT_BIT];   // level
					end
					default: ;   // unmapped
				endcase
			end
		end
	end

	// readback mux, unused bits stay zero
	always_comb begin
		rd_mux = '0;
		case (host_addr_i)
			`GLUE_ADDR_MEM:     rd_mux[$bits(mem_cfg_q)-1:0] = mem_cfg_q;
			`GLUE_ADDR_CPU:     rd_mux[$bits(cpu_cfg_q)-1:0] = cpu_cfg_q;
			`GLUE_ADDR_CHIPSET: rd_mux[$bits(chipset_cfg_q)-1:0] = chipset_cfg_q;
			`GLUE_ADDR_CTRL: begin
				rd_mux[`GLUE_CTRL_CPURST_BIT] = cpu_rst_q;
				rd_mux[`GLUE_CTRL_CPUHLT_BIT] = cpu_halt_q;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			rdata_q <= '0;
		else if (host_re_i)
			rdata_q <= rd_mux;   // data one cycle after re, else hold
	end

	// video standard only changes while the system is in reset
	always_ff @(posedge clk) begin
		if (reset)
			ntsc_q <= 1'b0;
		else if (sys_reset_i)
			ntsc_q <= chipset_cfg_q[NTSC_BIT];
	end

	assign host_rdata_o = rdata_q;
	assign mem_cfg_o    = mem_cfg_q;
	assign cpu_cfg_o    = cpu_cfg_q;
	assign ntsc_o       = ntsc_q;
	assign usr_reset_o  = usr_reset_q;
	assign cpu_rst_o    = cpu_rst_q;
	assign cpu_halt_o   = cpu_halt_q;

endmodule

// ==== logic/reset_sequencer.sv ====
// ----------------------------------------
// reset source merge and synchronizer
// frame counting system reset FSM
// ----------------------------------------
`timescale 1ns/1ps
`include "glue_params.svh"

module reset_sequencer (
	input  logic clk,
	input  logic reset,           // power-on
	input  logic usr_reset_i,     // pulse from config regs
	input  logic kbd_reset_i,     // ctrl-amiga-amiga
	input  logic rst_ext_i,
	input  logic cpu_reset_n_i,   // cpu driving reset out
	input  logic cpu_rst_i,       // host held cpu reset
	input  logic sof_i,           // start of frame
	output logic sys_reset_o,
	output logic cpu_reset_n_o
);

	localparam int unsigned FRAME_CNT_W = $clog2(`GLUE_RESET_FRAMES + 1);
	localparam logic [FRAME_CNT_W-1:0] FRAME_LAST = FRAME_CNT_W'(`GLUE_RESET_FRAMES - 1);

	glue_pkg::rst_state_t   state_q;
	glue_pkg::rst_state_t   state_d;
	logic [FRAME_CNT_W-1:0] frame_cnt_q;
	logic                   src_any;
	logic                   src_meta_q;
	logic                   src_sync_q;
	logic                   sys_reset_q;

	assign src_any = usr_reset_i | kbd_reset_i | rst_ext_i | ~cpu_reset_n_i;

	// two flop sync, sources are async to clk
	always_ff @(posedge clk) begin
		if (reset) begin
			src_meta_q <= 1'b0;
			src_sync_q <= 1'b0;
		end else begin
			src_meta_q <= src_any;
			src_sync_q <= src_meta_q;
		end
	end

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_comb begin
		state_d = state_q;
		if (src_sync_q)
			state_d = glue_pkg::RST_HOLD;   // any state
		else begin
			case (state_q)
				glue_pkg::RST_HOLD:  state_d = glue_pkg::RST_COUNT;
				glue_pkg::RST_COUNT: if (sof_i && frame_cnt_q == FRAME_LAST)
					state_d = glue_pkg::RST_RUN;
				default: ;   // stay running
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q     <= glue_pkg::RST_HOLD;
			frame_cnt_q <= '0;
			sys_reset_q <= 1'b1;
		end else begin
			state_q     <= state_d;
			sys_reset_q <= (state_q != glue_pkg::RST_RUN);   // one edge behind state
			if (state_q != glue_pkg::RST_COUNT)
				frame_cnt_q <= '0;
			else if (sof_i)
				frame_cnt_q <= frame_cnt_q + 1'b1;   // frames since release
		end
	end

	assign sys_reset_o   = sys_reset_q;
	assign cpu_reset_n_o = ~(sys_reset_q | cpu_rst_i);

endmodule

// ==== logic/irq_encoder.sv ====
// ----------------------------------------
// m68k ipl encoder with level 7 override
// ----------------------------------------
`timescale 1ns/1ps

module irq_encoder (
	input  logic                clk,
	input  logic                reset,
	input  glue_pkg::irq_vec_t  irq_i,     // levels 1 to 6
	input  logic                int7_i,    // action replay nmi
	output glue_pkg::ipl_t      ipl_n_o
);

	logic [2:0]     level;
	glue_pkg::ipl_t ipl_n_d;
	glue_pkg::ipl_t ipl_n_q;

	// scan upwards so the highest request wins
	always_comb begin
		level = 3'd0;
		for (int i = 0; i < $bits(irq_i); i++) begin
			if (irq_i[i])
				level = 3'(i + 1);
		end
	end

	assign ipl_n_d = int7_i ? 3'b000 : ~level;   // level 7 beats everything

	always_ff @(posedge clk) begin
		if (reset)
			ipl_n_q <= 3'b111;   // no interrupt
		else
			ipl_n_q <= ipl_n_d;
	end

	assign ipl_n_o = ipl_n_q;

endmodule

// ==== logic/status_indicators.sv ====
// ----------------------------------------
// mcu vsync toggle, dimming power led
// turbo chip ram and kick decisions
// ----------------------------------------
`timescale 1ns/1ps
`include "glue_params.svh"

module status_indicators (
	input  logic               clk,
	input  logic               reset,
	input  logic               vsync_n_i,
	input  logic               hsync_n_i,
	input  logic               led_n_i,    // cia led bit, high is off
	input  logic               turbo_i,
	input  logic               ovl_i,      // kickstart overlay
	input  glue_pkg::mem_cfg_t mem_cfg_i,
	input  glue_pkg::cpu_cfg_t cpu_cfg_i,
	output logic               mcu_vsync_o,
	output logic               pwrled_o,
	output logic               turbochipram_o,
	output logic               turbokick_o
);

	localparam int FAST_CHIP_BIT = 2;
	localparam int FAST_KICK_BIT = 3;

	logic                       vsync_del_q;
	logic                       vsync_t_q;
	logic                       vsync_fall;
	logic [`GLUE_LED_CNT_W-1:0] led_cnt_q;
	logic                       led_dim_q;

	// ----------------------------------------
	// vsync for the mcu osd update
	// ----------------------------------------
	assign vsync_fall = ~vsync_n_i & vsync_del_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_del_q <= 1'b1;   // sync idles high
			vsync_t_q   <= 1'b0;
		end else begin
			vsync_del_q <= vsync_n_i;
			vsync_t_q   <= vsync_t_q ^ vsync_fall;   // flip per frame
		end
	end

	// ----------------------------------------
	// led pwm, low duty cycle when dimmed
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt_q <= '0;
			led_dim_q <= 1'b0;
		end else begin
			if (hsync_n_i)
				led_cnt_q <= led_cnt_q + 1'b1;
			led_dim_q <= |led_cnt_q;   // low once per wrap
		end
	end

	// dimmed in off state and in turbo mode
	assign pwrled_o = ~(led_n_i & (led_dim_q | ~turbo_i));

	// 2 MB chip with fast chip, only outside overlay
	assign turbochipram_o = ~ovl_i & cpu_cfg_i[FAST_CHIP_BIT] & (&mem_cfg_i[1:0]);
	assign turbokick_o    = ~ovl_i & cpu_cfg_i[FAST_KICK_BIT];

	assign mcu_vsync_o = vsync_t_q;

endmodule

// ==== logic/glue_top.sv ====
// ----------------------------------------
// system glue top level
// config, reset, irq and status blocks
// ----------------------------------------
`timescale 1ns/1ps

module glue_top (
	input  logic                clk,
	input  logic                reset,
	// host register port
	input  glue_pkg::reg_addr_t host_addr_i,
	input  glue_pkg::reg_data_t host_wdata_i,
	input  logic                host_we_i,
	input  logic                host_re_i,
	output glue_pkg::reg_data_t host_rdata_o,
	// reset sources
	input  logic                kbd_reset_i,
	input  logic                rst_ext_i,
	input  logic                cpu_reset_n_i,
	// chipset side
	input  logic                sof_i,
	input  glue_pkg::irq_vec_t  irq_i,
	input  logic                int7_i,
	input  logic                vsync_n_i,
	input  logic                hsync_n_i,
	input  logic                led_n_i,
	input  logic                turbo_i,
	input  logic                ovl_i,
	output logic                cpu_reset_n_o,
	output logic                sys_reset_o,
	output glue_pkg::ipl_t      ipl_n_o,
	output logic                ntsc_o,
	output logic                mcu_vsync_o,
	output logic                pwrled_o,
	output logic                turbochipram_o,
	output logic                turbokick_o,
	output glue_pkg::mem_cfg_t  memcfg_o,
	output glue_pkg::cpu_cfg_t  cpu_config_o,
	output logic                cpu_halt_o
);

	logic usr_reset;   // osd user reset pulse
	logic cpu_rst;     // host held cpu reset

	sys_config_regs CONFIG1 (
		.clk(clk), .reset(reset),
		.host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
		.host_we_i(host_we_i), .host_re_i(host_re_i), .host_rdata_o(host_rdata_o),
		.sys_reset_i(sys_reset_o),
		.mem_cfg_o(memcfg_o), .cpu_cfg_o(cpu_config_o), .ntsc_o(ntsc_o),
		.usr_reset_o(usr_reset), .cpu_rst_o(cpu_rst), .cpu_halt_o(cpu_halt_o)
	);

	reset_sequencer RSTSEQ1 (
		.clk(clk), .reset(reset),
		.usr_reset_i(usr_reset), .kbd_reset_i(kbd_reset_i), .rst_ext_i(rst_ext_i),
		.cpu_reset_n_i(cpu_reset_n_i), .cpu_rst_i(cpu_rst), .sof_i(sof_i),
		.sys_reset_o(sys_reset_o), .cpu_reset_n_o(cpu_reset_n_o)
	);

	irq_encoder IRQENC1 (
		.clk(clk), .reset(reset),
		.irq_i(irq_i), .int7_i(int7_i), .ipl_n_o(ipl_n_o)
	);

	status_indicators STATUS1 (
		.clk(clk), .reset(reset),
		.vsync_n_i(vsync_n_i), .hsync_n_i(hsync_n_i), .led_n_i(led_n_i),
		.turbo_i(turbo_i), .ovl_i(ovl_i),
		.mem_cfg_i(memcfg_o), .cpu_cfg_i(cpu_config_o),
		.mcu_vsync_o(mcu_vsync_o), .pwrled_o(pwrled_o),
		.turbochipram_o(turbochipram_o), .turbokick_o(turbokick_o)
	);

endmodule

// ==== dv/glue_asserts.sv ====
// ----------------------------------------
// bound checks on system reset vs cpu
// reset and on the level 7 override
// ----------------------------------------
`timescale 1ns/1ps

module glue_asserts (
	input  logic           clk,
	input  logic           reset,
	input  logic           sys_reset_i,     // tied low where unused
	input  logic           cpu_reset_n_i,
	input  logic           int7_i,          // tied low where unused
	input  glue_pkg::ipl_t ipl_n_i
);

	int fail_count;   // failed assertions so far

	initial fail_count = 0;

	// cpu held in reset during the whole system reset
	cpu_in_sys_reset: assert property (
		@(posedge clk) disable iff (reset) sys_reset_i |-> !cpu_reset_n_i
	) else begin
		fail_count++;
		$error("cpu_reset_n_o high while sys_reset_o is high");
	end

	// nmi level wins one cycle later
	level7_override: assert property (
		@(posedge clk) disable iff (reset) int7_i |=> (ipl_n_i == 3'b000)
	) else begin
		fail_count++;
		$error("ipl_n_o not level 7 one cycle after int7_i");
	end

endmodule

// ==== dv/glue_tb.sv ====
// ----------------------------------------
// directed testbench for glue_top
// readback, reset sequence, ntsc latch,
// irq priority and status outputs
// ----------------------------------------
`timescale 1ns/1ps
`include "glue_params.svh"

module glue_tb;

	localparam int          CLK_PERIOD = 20;
	localparam logic [31:0] SEED       = 32'h6f44_6572;

	// rough length of each test in cycles
	localparam int READBACK_CYCLES = 80;
	localparam int RESET_CYCLES    = 160;
	localparam int NTSC_CYCLES     = 60;
	localparam int IRQ_CYCLES      = 40;
	localparam int STATUS_CYCLES   = 180;
	localparam int TIMEOUT_CYCLES  = 2 * (READBACK_CYCLES + RESET_CYCLES + NTSC_CYCLES
		+ IRQ_CYCLES + STATUS_CYCLES) + 20;

	logic                clk;
	logic                reset;
	glue_pkg::reg_addr_t host_addr_i;
	glue_pkg::reg_data_t host_wdata_i;
	logic                host_we_i;
	logic                host_re_i;
	glue_pkg::reg_data_t host_rdata_o;
	logic                kbd_reset_i;
	logic                rst_ext_i;
	logic                cpu_reset_n_i;
	logic                sof_i;
	glue_pkg::irq_vec_t  irq_i;
	logic                int7_i;
	logic                vsync_n_i;
	logic                hsync_n_i;
	logic                led_n_i;
	logic                turbo_i;
	logic                ovl_i;
	logic                cpu_reset_n_o;
	logic                sys_reset_o;
	glue_pkg::ipl_t      ipl_n_o;
	logic                ntsc_o;
	logic                mcu_vsync_o;
	logic                pwrled_o;
	logic                turbochipram_o;
	logic                turbokick_o;
	glue_pkg::mem_cfg_t  memcfg_o;
	glue_pkg::cpu_cfg_t  cpu_config_o;
	logic                cpu_halt_o;

	logic [31:0]                lfsr_q = SEED;
	glue_pkg::chipset_cfg_t     chipset_shadow;   // last chipset write
	logic [`GLUE_LED_CNT_W-1:0] led_cnt_m;        // led counter model
	logic                       led_dim_m;

	glue_top UUT (.*);

	bind reset_sequencer glue_asserts RST_CHK (
		.clk(clk), .reset(reset), .sys_reset_i(sys_reset_o),
		.cpu_reset_n_i(cpu_reset_n_o), .int7_i(1'b0), .ipl_n_i(3'b111)
	);
	bind irq_encoder glue_asserts IRQ_CHK (
		.clk(clk), .reset(reset), .sys_reset_i(1'b0),
		.cpu_reset_n_i(1'b1), .int7_i(int7_i), .ipl_n_i(ipl_n_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic stop_failed();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got 'h%0h, expected 'h%0h",
				$time, what, actual, expected);
			stop_failed();
		end
	endtask

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	// implemented bits per register
	function automatic glue_pkg::reg_data_t reg_mask(input glue_pkg::reg_addr_t addr);
		case (addr)
			`GLUE_ADDR_MEM:     return 16'((1 << $bits(glue_pkg::mem_cfg_t)) - 1);
			`GLUE_ADDR_CPU:     return 16'((1 << $bits(glue_pkg::cpu_cfg_t)) - 1);
			`GLUE_ADDR_CHIPSET: return 16'((1 << $bits(glue_pkg::chipset_cfg_t)) - 1);
			default:            return 16'h0000;
		endcase
	endfunction

	// highest requested level searched from the top
	function automatic logic [2:0] highest_level(input glue_pkg::irq_vec_t req);
		logic [2:0] lvl;
		lvl = 3'd0;
		for (int i = 6; i >= 1; i--) begin
			if (req[i-1] && lvl == 3'd0)
				lvl = 3'(i);
		end
		return lvl;
	endfunction

	// all tasks start and end right after a falling edge
	task automatic write_reg(input glue_pkg::reg_addr_t addr, input glue_pkg::reg_data_t data);
		host_addr_i  = addr;
		host_wdata_i = data;
		host_we_i    = 1'b1;
		@(negedge clk);
		host_we_i = 1'b0;
	endtask

	task automatic read_reg(input glue_pkg::reg_addr_t addr, output glue_pkg::reg_data_t data);
		host_addr_i = addr;
		host_re_i   = 1'b1;
		@(negedge clk);
		host_re_i = 1'b0;
		data      = host_rdata_o;   // registered one cycle after re
	endtask

	// sys_reset_o falls within a few cycles of the last frame start
	task automatic wait_release();
		int n;
		n = 0;
		while (sys_reset_o && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (sys_reset_o) begin
			$display("sys_reset_o stayed high after all frame starts at %0t ns", $time);
			stop_failed();
		end
	endtask

	// feeds the frame starts once the sources are released
	task automatic run_frames(input string what);
		repeat (5) @(negedge clk);   // sync and hold to count
		repeat (`GLUE_RESET_FRAMES) begin
			compare(32'(sys_reset_o), 32'(1'b1), {what, ": sys_reset_o before frame start"});
			sof_i = 1'b1;
			@(negedge clk);
			sof_i = 1'b0;
			repeat (2) @(negedge clk);
		end
		wait_release();
		compare(32'(cpu_reset_n_o), 32'(1'b1), {what, ": cpu_reset_n_o after release"});
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic readback_regs();
		glue_pkg::reg_data_t data;
		glue_pkg::reg_data_t rdata;
		glue_pkg::reg_data_t expd;
		read_reg(`GLUE_ADDR_CTRL, rdata);
		compare(32'(rdata), 32'h0, "ctrl after power-on");
		repeat (8) begin
			for (int a = 0; a < 3; a++) begin
				data = 16'(rand_bits(16));
				expd = data & reg_mask(4'(a));
				write_reg(4'(a), data);
				if (a == `GLUE_ADDR_MEM)
					compare(32'(memcfg_o), 32'(expd), "memcfg_o after write");
				if (a == `GLUE_ADDR_CPU)
					compare(32'(cpu_config_o), 32'(expd), "cpu_config_o after write");
				if (a == `GLUE_ADDR_CHIPSET)
					chipset_shadow = 5'(expd);
				read_reg(4'(a), rdata);
				compare(32'(rdata), 32'(expd), "register readback");
			end
		end
	endtask

	task automatic sequence_resets();
		glue_pkg::reg_data_t rdata;
		run_frames("power-on");
		rst_ext_i = 1'b1;   // external reset button
		repeat (5) @(negedge clk);
		compare(32'(sys_reset_o), 32'(1'b1), "sys_reset_o with rst_ext_i held");
		rst_ext_i = 1'b0;
		run_frames("external");
		write_reg(`GLUE_ADDR_CTRL, 16'(1 << `GLUE_CTRL_USRRST_BIT));
		read_reg(`GLUE_ADDR_CTRL, rdata);
		compare(32'(rdata), 32'h0, "ctrl readback user reset bit");
		run_frames("user");
		// held cpu reset while the system keeps running
		write_reg(`GLUE_ADDR_CTRL, 16'(1 << `GLUE_CTRL_CPURST_BIT));
		repeat (6) begin
			compare(32'(cpu_reset_n_o), 32'(1'b0), "cpu_reset_n_o with cpu reset bit");
			compare(32'(sys_reset_o), 32'(1'b0), "sys_reset_o with cpu reset bit");
			@(negedge clk);
		end
		read_reg(`GLUE_ADDR_CTRL, rdata);
		compare(32'(rdata), 32'(1 << `GLUE_CTRL_CPURST_BIT), "ctrl readback cpu reset");
		write_reg(`GLUE_ADDR_CTRL, 16'(1 << `GLUE_CTRL_CPUHLT_BIT));
		compare(32'(cpu_reset_n_o), 32'(1'b1), "cpu_reset_n_o after clearing bit");
		compare(32'(cpu_halt_o), 32'(1'b1), "cpu_halt_o set");
		read_reg(`GLUE_ADDR_CTRL, rdata);
		compare(32'(rdata), 32'(1 << `GLUE_CTRL_CPUHLT_BIT), "ctrl readback cpu halt");
		write_reg(`GLUE_ADDR_CTRL, 16'h0000);
		compare(32'(cpu_halt_o), 32'(1'b0), "cpu_halt_o cleared");
	endtask

	task automatic latch_ntsc();
		logic ntsc_old;
		ntsc_old = chipset_shadow[1];
		compare(32'(ntsc_o), 32'(ntsc_old), "ntsc_o before change");
		chipset_shadow = chipset_shadow ^ 5'h02;   // flip ntsc
		write_reg(`GLUE_ADDR_CHIPSET, 16'(chipset_shadow));
		repeat (4) @(negedge clk);
		compare(32'(ntsc_o), 32'(ntsc_old), "ntsc_o while running");
		write_reg(`GLUE_ADDR_CTRL, 16'(1 << `GLUE_CTRL_USRRST_BIT));
		run_frames("ntsc");
		compare(32'(ntsc_o), 32'(chipset_shadow[1]), "ntsc_o after user reset");
	endtask

	task automatic encode_irqs();
		logic [2:0] expd;
		repeat (20) begin
			irq_i  = 6'(rand_bits(6));
			int7_i = 1'b0;
			expd   = ~highest_level(irq_i);
			@(negedge clk);
			compare(32'(ipl_n_o), 32'(expd), "ipl_n_o for irq pattern");
		end
		repeat (8) begin
			irq_i  = 6'(rand_bits(6));
			int7_i = 1'b1;   // nmi over anything
			@(negedge clk);
			compare(32'(ipl_n_o), 32'h0, "ipl_n_o with int7_i");
		end
		irq_i  = '0;
		int7_i = 1'b0;
		@(negedge clk);
		compare(32'(ipl_n_o), 32'h7, "ipl_n_o idle");
	endtask

	// hsync high stretch with the led model stepped per rising edge
	task automatic led_stretch(input logic turbo, input int cycles);
		logic led_exp;
		hsync_n_i = 1'b1;
		led_n_i   = 1'b1;
		turbo_i   = turbo;
		repeat (cycles) begin
			@(posedge clk);
			led_dim_m = |led_cnt_m;
			led_cnt_m = led_cnt_m + 1'b1;
			@(negedge clk);
			led_exp = ~(led_dim_m | ~turbo);
			compare(32'(pwrled_o), 32'(led_exp), "pwrled_o");
		end
		hsync_n_i = 1'b0;
	endtask

	task automatic exercise_status();
		logic                vs_exp;
		glue_pkg::mem_cfg_t  mem;
		glue_pkg::cpu_cfg_t  cpu;
		logic                ovl;
		logic                chip_exp;
		logic                kick_exp;
		vs_exp = 1'b0;
		repeat (4) begin
			vsync_n_i = 1'b0;
			@(negedge clk);
			vs_exp = ~vs_exp;
			compare(32'(mcu_vsync_o), 32'(vs_exp), "mcu_vsync_o after falling edge");
			@(negedge clk);
			compare(32'(mcu_vsync_o), 32'(vs_exp), "mcu_vsync_o while low");
			vsync_n_i = 1'b1;
			repeat (2) @(negedge clk);
			compare(32'(mcu_vsync_o), 32'(vs_exp), "mcu_vsync_o while high");
		end
		led_stretch(1'b0, 16);
		led_stretch(1'b1, 16);
		led_n_i = 1'b0;   // led on at full brightness
		@(negedge clk);
		compare(32'(pwrled_o), 32'(1'b1), "pwrled_o with led_n_i low");
		for (int i = 0; i < 32; i++) begin
			mem = 6'(rand_bits(6));
			cpu = 4'(rand_bits(4));
			ovl = 1'(rand_bits(1));
			if (i[0] == 1'b0)
				mem[1:0] = 2'b11;   // 2 MB chip half the time
			write_reg(`GLUE_ADDR_MEM, 16'(mem));
			write_reg(`GLUE_ADDR_CPU, 16'(cpu));
			ovl_i = ovl;
			@(negedge clk);
			chip_exp = !ovl && cpu[2] && mem[1:0] == 2'b11;
			kick_exp = !ovl && cpu[3];
			compare(32'(turbochipram_o), 32'(chip_exp), "turbochipram_o");
			compare(32'(turbokick_o), 32'(kick_exp), "turbokick_o");
		end
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		stop_failed();
	end

	initial begin
		reset          = 1'b1;
		host_addr_i    = '0;
		host_wdata_i   = '0;
		host_we_i      = 1'b0;
		host_re_i      = 1'b0;
		kbd_reset_i    = 1'b0;
		rst_ext_i      = 1'b0;
		cpu_reset_n_i  = 1'b1;
		sof_i          = 1'b0;
		irq_i          = '0;
		int7_i         = 1'b0;
		vsync_n_i      = 1'b1;
		hsync_n_i      = 1'b0;   // led counter parked
		led_n_i        = 1'b0;
		turbo_i        = 1'b0;
		ovl_i          = 1'b0;
		chipset_shadow = `GLUE_CHIPSET_DEFAULT;
		led_cnt_m      = '0;
		led_dim_m      = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		readback_regs();
		sequence_resets();
		latch_ntsc();
		encode_irqs();
		exercise_status();

		if (UUT.RSTSEQ1.RST_CHK.fail_count + UUT.IRQENC1.IRQ_CHK.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("bound assertions reported failures");
			stop_failed();
		end
	end

endmodule

// ==== sources.f ====
+incdir+include
logic/glue_pkg.sv
logic/sys_config_regs.sv
logic/reset_sequencer.sv
logic/irq_encoder.sv
logic/status_indicators.sv
logic/glue_top.sv
dv/glue_asserts.sv
dv/glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sources.f --top-module glue_tb -o glue_sim

./obj_dir/glue_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
else
	exit 1
fi
